/* src/sdio_data_defs.svh */
// SDIO data path constants for CRC, block length and register map
`ifndef SDIO_DATA_DEFS_SVH
`define SDIO_DATA_DEFS_SVH

// CRC-16-CCITT, MSB first, starts from zero
`define SDIO_CRC_POLY     16'h1021
`define SDIO_CRC_W        16

// CRC cycles after the last data nibble
`define SDIO_CRC_NIBBLES  16

// Byte count of one block
`define SDIO_LEN_W        10
`define SDIO_MAX_LEN      512

// Register map
`define SDIO_ADDR_W       2
`define SDIO_REG_LEN      2'd0
`define SDIO_REG_CTRL     2'd1

// Control register bits
`define SDIO_CTRL_DIR_BIT 0
`define SDIO_CTRL_GO_BIT  1

`endif

/* src/sdio_data_pkg.sv */
// Shared types for the SDIO data path: transfer direction and bus byte views
`default_nettype none

package sdio_data_pkg;

  // Write moves data host to device, read moves it device to host
  typedef enum logic {
    SDIO_DIR_WRITE = 1'b0,
    SDIO_DIR_READ  = 1'b1
  } sdio_dir_e;

  // Nibble pair as seen on the 4-bit bus
  typedef struct packed {
    logic [3:0] hi;
    logic [3:0] lo;
  } sdio_nib_s;

  // One bus byte, taken whole or as the two nibbles sent high first
  typedef union packed {
    logic [7:0] data;
    sdio_nib_s  nib;
  } sdio_byte_u;

endpackage

`default_nettype wire

/* src/sdio_data_if.sv */
// Control link from the register block to the data PHY
`timescale 1ns/1ps
`default_nettype none
`include "sdio_data_defs.svh"

interface sdio_data_if
  import sdio_data_pkg::*;
();

  // Request side, held steady from start until done
  logic                   start;
  sdio_dir_e              dir;
  logic [`SDIO_LEN_W-1:0] len;

  // Completion side
  logic                   done;
  logic                   crc_good;

  modport cfg_mp (
    output start,
    output dir,
    output len,
    input  done,
    input  crc_good
  );

  modport phy_mp (
    input  start,
    input  dir,
    input  len,
    output done,
    output crc_good
  );

endinterface

`default_nettype wire

/* src/sdio_crc16_lane.sv */
// Serial CRC-16 for one SDIO data line, one bit per enabled cycle
`timescale 1ns/1ps
`default_nettype none
`include "sdio_data_defs.svh"

module sdio_crc16_lane (
  input  wire                    clk,
  input  wire                    rst,
  input  wire                    i_clear,
  input  wire                    i_en,
  input  wire                    i_bit,
  output logic [`SDIO_CRC_W-1:0] o_crc
);

  logic [`SDIO_CRC_W-1:0] crc_q;
  logic                   feedback;

  // Top bit leaving the register meets the incoming data bit
  assign feedback = crc_q[`SDIO_CRC_W-1] ^ i_bit;

  always_ff @(posedge clk) begin
    if (rst) begin
      crc_q <= '0;
    end else if (i_clear) begin
      crc_q <= '0;
    end else if (i_en) begin
      crc_q <= {crc_q[`SDIO_CRC_W-2:0], 1'b0} ^ (feedback ? `SDIO_CRC_POLY : '0);
    end
  end

  assign o_crc = crc_q;

  // PHY keeps the lanes cleared only outside the data phase
  a_clear_en_excl: assert property (
    @(posedge clk) disable iff (rst) !(i_clear && i_en)
  ) else $error("CRC lane cleared and enabled in the same cycle");

endmodule

`default_nettype wire

/* src/sdio_data_cfg.sv */
// SDIO data register block: length and direction, go launch, busy and status
`timescale 1ns/1ps
`default_nettype none
`include "sdio_data_defs.svh"

module sdio_data_cfg
  import sdio_data_pkg::*;
(
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     i_cfg_wr_stb,
  input  wire [`SDIO_ADDR_W-1:0]  i_cfg_addr,
  input  wire [`SDIO_LEN_W-1:0]   i_cfg_wdata,
  output logic                    o_busy,
  output logic                    o_crc_good,
  output logic                    o_done,
  sdio_data_if.cfg_mp             ctl
);

  logic                   wr_ok;
  logic                   go_wr;
  logic                   start_q;
  logic                   busy_q;
  logic                   done_q;
  logic                   crc_good_q;
  sdio_dir_e              dir_q;
  logic [`SDIO_LEN_W-1:0] len_q;

  // Register writes only land between transfers
  assign wr_ok = i_cfg_wr_stb && !busy_q;
  assign go_wr = wr_ok && (i_cfg_addr == `SDIO_REG_CTRL) && i_cfg_wdata[`SDIO_CTRL_GO_BIT];

  always_ff @(posedge clk) begin
    if (rst) begin
      start_q    <= 1'b0;
      busy_q     <= 1'b0;
      done_q     <= 1'b0;
      crc_good_q <= 1'b0;
      dir_q      <= SDIO_DIR_WRITE;
      len_q      <= '0;
    end else begin
      // Go is never stored, it lives for one cycle as start
      start_q <= go_wr;
      done_q  <= ctl.done;

      if (go_wr) begin
        busy_q     <= 1'b1;
        crc_good_q <= 1'b0;
      end else if (ctl.done) begin
        busy_q     <= 1'b0;
        crc_good_q <= ctl.crc_good;
      end

      if (wr_ok && (i_cfg_addr == `SDIO_REG_LEN)) begin
        len_q <= i_cfg_wdata;
      end
      // Direction rides along with go in the same write
      if (wr_ok && (i_cfg_addr == `SDIO_REG_CTRL)) begin
        dir_q <= sdio_dir_e'(i_cfg_wdata[`SDIO_CTRL_DIR_BIT]);
      end
    end
  end

  assign ctl.start  = start_q;
  assign ctl.dir    = dir_q;
  assign ctl.len    = len_q;
  assign o_busy     = busy_q;
  assign o_done     = done_q;
  assign o_crc_good = crc_good_q;

  // One transfer in flight: no second start before the PHY reports done
  a_single_start: assert property (
    @(posedge clk) disable iff (rst) ctl.start |=> (!ctl.start throughout ctl.done[->1])
  ) else $error("start pulsed again before done");

  a_len_range: assert property (
    @(posedge clk) disable iff (rst)
    ctl.start |-> (ctl.len != '0) && (ctl.len <= `SDIO_MAX_LEN)
  ) else $error("transfer started with length out of range");

endmodule

`default_nettype wire

/* src/sdio_data_phy.sv */
// SDIO 4-bit data PHY: one block per start, nibble packing and four line CRCs
`timescale 1ns/1ps
`default_nettype none
`include "sdio_data_defs.svh"

module sdio_data_phy
  import sdio_data_pkg::*;
(
  input  wire         clk,
  input  wire         rst,
  sdio_data_if.phy_mp ctl,
  output logic        o_wr_stb,
  output logic [7:0]  o_wr_data,
  output logic        o_rd_req,
  input  wire         i_rd_stb,
  input  wire  [7:0]  i_rd_data,
  input  wire  [3:0]  i_sd_dat,
  output logic [3:0]  o_sd_dat,
  output logic        o_sd_dir
);

  typedef enum logic [3:0] {
    ST_IDLE,
    ST_WAIT_START,
    ST_WR_DATA,
    ST_WR_CRC,
    ST_WR_END,
    ST_RD_START,
    ST_RD_DATA,
    ST_RD_CRC,
    ST_RD_END,
    ST_DONE
  } state_e;

  state_e                 state;
  logic [`SDIO_LEN_W-1:0] cnt;
  logic [`SDIO_LEN_W-1:0] len_last;
  logic                   lo_phase;
  logic                   data_last;
  logic                   crc_last;

  sdio_byte_u             buf_q;
  sdio_byte_u             tx_byte;

  logic [`SDIO_CRC_W-1:0] lane_crc [4];
  logic                   lane_clear;
  logic                   lane_en;
  logic [3:0]             lane_bit;
  logic [3:0]             crc_tx;
  logic [3:0]             crc_match;

  // cnt counts bytes in the data phase and cycles in the CRC phase
  assign len_last  = ctl.len - 1'b1;
  assign data_last = lo_phase && (cnt == len_last);
  assign crc_last  = (cnt == `SDIO_LEN_W'(`SDIO_CRC_NIBBLES - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= ST_IDLE;
      cnt      <= '0;
      lo_phase <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          cnt      <= '0;
          lo_phase <= 1'b0;
          if (ctl.start) begin
            state <= (ctl.dir == SDIO_DIR_READ) ? ST_RD_START : ST_WAIT_START;
          end
        end
        ST_WAIT_START: begin
          // Host may idle any number of cycles before its start nibble
          if (i_sd_dat == 4'h0) begin
            state <= ST_WR_DATA;
          end
        end
        ST_RD_START: begin
          state <= ST_RD_DATA;
        end
        ST_WR_DATA, ST_RD_DATA: begin
          lo_phase <= !lo_phase;
          if (data_last) begin
            cnt   <= '0;
            state <= (state == ST_WR_DATA) ? ST_WR_CRC : ST_RD_CRC;
          end else if (lo_phase) begin
            cnt <= cnt + 1'b1;
          end
        end
        ST_WR_CRC, ST_RD_CRC: begin
          cnt <= cnt + 1'b1;
          if (crc_last) begin
            state <= (state == ST_WR_CRC) ? ST_WR_END : ST_RD_END;
          end
        end
        ST_WR_END, ST_RD_END: begin
          state <= ST_DONE;
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // Byte buffer: assembled from nibbles in a write, holds the fetched byte in a read
  always_ff @(posedge clk) begin
    if (state == ST_WR_DATA) begin
      if (lo_phase) begin
        buf_q.nib.lo <= i_sd_dat;
      end else begin
        buf_q.nib.hi <= i_sd_dat;
      end
    end else if (i_rd_stb) begin
      buf_q.data <= i_rd_data;
    end
  end

  // Sink strobe follows each completed byte by one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      o_wr_stb <= 1'b0;
    end else begin
      o_wr_stb <= (state == ST_WR_DATA) && lo_phase;
    end
  end

  assign o_wr_data = buf_q.data;

  // High nibble goes out in the same cycle the source answers
  // A missing answer leaves the previous byte in the buffer
  assign tx_byte.data = i_rd_stb ? i_rd_data : buf_q.data;

  always_comb begin
    case (state)
      ST_RD_START: o_sd_dat = 4'h0;
      ST_RD_DATA:  o_sd_dat = lo_phase ? buf_q.nib.lo : tx_byte.nib.hi;
      ST_RD_CRC:   o_sd_dat = crc_tx;
      default:     o_sd_dat = 4'hF;
    endcase
  end

  assign o_sd_dir = (state == ST_RD_START) || (state == ST_RD_DATA) ||
                    (state == ST_RD_CRC) || (state == ST_RD_END);

  // Next byte is asked for after the start nibble and after every low nibble but the last
  assign o_rd_req = (state == ST_RD_START) ||
                    ((state == ST_RD_DATA) && lo_phase && !data_last);

  // Lanes see the bus as driven in a read and as sampled in a write
  assign lane_clear = (state == ST_IDLE);
  assign lane_en    = (state == ST_WR_DATA) || (state == ST_RD_DATA);
  assign lane_bit   = o_sd_dir ? o_sd_dat : i_sd_dat;

  for (genvar g = 0; g < 4; g++) begin : g_lane
    logic [`SDIO_CRC_W-1:0] host_crc;

    sdio_crc16_lane u_crc (
      .clk     (clk),
      .rst     (rst),
      .i_clear (lane_clear),
      .i_en    (lane_en),
      .i_bit   (lane_bit[g]),
      .o_crc   (lane_crc[g])
    );

    // CRC received from the host on this line, MSB first
    always_ff @(posedge clk) begin
      if (state == ST_WR_CRC) begin
        host_crc <= {host_crc[`SDIO_CRC_W-2:0], i_sd_dat[g]};
      end
    end

    assign crc_match[g] = (host_crc == lane_crc[g]);
    // ~cnt walks the lane CRC from bit 15 down to bit 0
    assign crc_tx[g]    = lane_crc[g][~cnt[3:0]];
  end

  assign ctl.done     = (state == ST_DONE);
  // Nothing to check on a read, so it always reports good
  assign ctl.crc_good = (ctl.dir == SDIO_DIR_READ) || (&crc_match);

  a_dir_read_only: assert property (
    @(posedge clk) disable iff (rst) o_sd_dir |-> (ctl.dir == SDIO_DIR_READ)
  ) else $error("data lines driven during a write transfer");

  // Source has exactly one cycle to answer, otherwise a stale byte goes out
  a_rd_answer: assert property (
    @(posedge clk) disable iff (rst) o_rd_req |=> i_rd_stb
  ) else $error("source missed its read slot");

  a_rd_unasked: assert property (
    @(posedge clk) disable iff (rst) i_rd_stb |-> $past(o_rd_req)
  ) else $error("read strobe without a request");

endmodule

`default_nettype wire

/* src/sdio_data_top.sv */
// SDIO 4-bit data path top: register block joined to the data PHY
`timescale 1ns/1ps
`default_nettype none
`include "sdio_data_defs.svh"

module sdio_data_top (
  input  wire                     clk,
  input  wire                     rst,

  // Register writes
  input  wire                     i_cfg_wr_stb,
  input  wire [`SDIO_ADDR_W-1:0]  i_cfg_addr,
  input  wire [`SDIO_LEN_W-1:0]   i_cfg_wdata,

  // Status
  output logic                    o_busy,
  output logic                    o_crc_good,
  output logic                    o_done,

  // Local byte sink for writes
  output logic                    o_wr_stb,
  output logic [7:0]              o_wr_data,

  // Local byte source for reads
  output logic                    o_rd_req,
  input  wire                     i_rd_stb,
  input  wire  [7:0]              i_rd_data,

  // SDIO data lines
  input  wire  [3:0]              i_sd_dat,
  output logic [3:0]              o_sd_dat,
  output logic                    o_sd_dir
);

  sdio_data_if ctl_if ();

  sdio_data_cfg u_cfg (
    .clk          (clk),
    .rst          (rst),
    .i_cfg_wr_stb (i_cfg_wr_stb),
    .i_cfg_addr   (i_cfg_addr),
    .i_cfg_wdata  (i_cfg_wdata),
    .o_busy       (o_busy),
    .o_crc_good   (o_crc_good),
    .o_done       (o_done),
    .ctl          (ctl_if.cfg_mp)
  );

  sdio_data_phy u_phy (
    .clk       (clk),
    .rst       (rst),
    .ctl       (ctl_if.phy_mp),
    .o_wr_stb  (o_wr_stb),
    .o_wr_data (o_wr_data),
    .o_rd_req  (o_rd_req),
    .i_rd_stb  (i_rd_stb),
    .i_rd_data (i_rd_data),
    .i_sd_dat  (i_sd_dat),
    .o_sd_dat  (o_sd_dat),
    .o_sd_dir  (o_sd_dir)
  );

endmodule

`default_nettype wire

/* tests/sdio_data_checker.sv */
// Scoreboard that checks SDIO data path bus nibbles, sink bytes, CRC status and timing
`timescale 1ns/1ps
`default_nettype none
`include "sdio_data_defs.svh"

module sdio_data_checker
  import sdio_data_pkg::*;
(
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   i_dir,
  input  wire [`SDIO_LEN_W-1:0] i_len,
  input  wire [7:0]             i_base,
  input  wire [7:0]             i_step,
  input  wire                   i_corrupt,
  input  wire                   i_busy,
  input  wire                   i_done,
  input  wire                   i_crc_good,
  input  wire                   i_wr_stb,
  input  wire [7:0]             i_wr_data,
  input  wire                   i_rd_req,
  input  wire [3:0]             i_sd_dat,
  input  wire                   i_sd_dir,
  output int                    o_errors
);

  logic [15:0] crc [4];
  sdio_byte_u  cur;
  logic [3:0]  exp_nib;
  logic        in_xfer;
  logic        busy_q;
  int          t;
  int          n;
  int          len2;
  int          nbytes;

  // Block byte k is base plus k times step modulo 256
  function automatic logic [7:0] table_byte(input int k);
    return i_base + 8'(k) * i_step;
  endfunction

  function automatic logic [15:0] crc_shift(input logic [15:0] c, input logic b);
    return {c[14:0], 1'b0} ^ ((c[15] ^ b) ? `SDIO_CRC_POLY : 16'h0);
  endfunction

  task automatic value_err(input string name, input logic [31:0] got, input logic [31:0] exp);
    $display("ERR %s: got %0h exp %0h at %0t", name, got, exp, $time);
    o_errors++;
  endtask

  task automatic text_err(input string msg);
    $display("Check failed: %s at %0t", msg, $time);
    o_errors++;
  endtask

  always @(posedge clk) begin
    if (rst) begin
      o_errors = 0;
      in_xfer  = 1'b0;
      busy_q   = 1'b0;
    end else begin
      // Busy rises in the start cycle at t = 0
      if (i_busy && !busy_q) begin
        in_xfer = 1'b1;
        t       = 0;
        nbytes  = 0;
        for (int g = 0; g < 4; g++) begin
          crc[g] = '0;
        end
      end
      busy_q = i_busy;
      len2   = 2 * i_len;
      if (i_done && !in_xfer) begin
        text_err("o_done pulsed with no transfer in flight");
      end else if (in_xfer && (i_busy == i_done)) begin
        text_err("o_busy out of step with start and done");
      end
      if (!in_xfer && (i_sd_dir || i_wr_stb || i_rd_req || (i_sd_dat != 4'hF))) begin
        text_err("bus not idle between transfers");
      end
      if (in_xfer && (i_dir == SDIO_DIR_READ)) begin
        // Start nibble then data high nibble first, line CRCs MSB first and the end nibble
        n = t - 2;
        if (t == 1) begin
          exp_nib = 4'h0;
        end else if ((n >= 0) && (n < len2)) begin
          cur.data = table_byte(n / 2);
          exp_nib  = n[0] ? cur.nib.lo : cur.nib.hi;
          for (int g = 0; g < 4; g++) begin
            crc[g] = crc_shift(crc[g], exp_nib[g]);
          end
        end else if ((n >= len2) && (n < len2 + 16)) begin
          for (int g = 0; g < 4; g++) begin
            exp_nib[g] = crc[g][15 - (n - len2)];
          end
        end else begin
          exp_nib = 4'hF;
        end
        if (i_sd_dat !== exp_nib) value_err("o_sd_dat", i_sd_dat, exp_nib);
        if (i_sd_dir !== ((t >= 1) && (t <= len2 + 18))) value_err("o_sd_dir", i_sd_dir, !i_sd_dir);
        if (i_done !== (t == len2 + 20)) value_err("o_done", i_done, !i_done);
        // Byte k is requested one cycle before its high nibble at t = 2k + 2
        if (i_rd_req !== ((t % 2 == 1) && (t < len2))) begin
          value_err("o_rd_req", i_rd_req, !i_rd_req);
        end
      end else if (in_xfer) begin
        if (i_sd_dir) value_err("o_sd_dir", i_sd_dir, 0);
        if (i_rd_req) value_err("o_rd_req", i_rd_req, 0);
        if (i_wr_stb && (nbytes >= i_len)) begin
          text_err("sink strobe beyond the block length");
        end else if (i_wr_stb && (i_wr_data !== table_byte(nbytes))) begin
          value_err("o_wr_data", i_wr_data, table_byte(nbytes));
        end
        if (i_wr_stb) nbytes++;
      end
      if (i_done && in_xfer) begin
        if (i_crc_good !== ((i_dir == SDIO_DIR_READ) || !i_corrupt)) begin
          value_err("o_crc_good", i_crc_good, !i_crc_good);
        end
        if ((i_dir == SDIO_DIR_WRITE) && (nbytes != i_len)) begin
          text_err("sink byte count differs from the block length");
        end
        in_xfer = 1'b0;
      end
      t++;
    end
  end

endmodule

`default_nettype wire

/* tests/tb_sdio_data.sv */
// Testbench for the SDIO 4-bit data path with a host bus model and a byte source
`timescale 1ns/1ps
`default_nettype none
`include "sdio_data_defs.svh"

module tb_sdio_data
  import sdio_data_pkg::*;
();

  localparam int NROWS = 9;

  typedef struct packed {
    sdio_dir_e              dir;
    logic [`SDIO_LEN_W-1:0] len;
    logic [7:0]             base;
    logic [7:0]             step;
    logic                   corrupt;
    logic                   extra_go;
  } row_t;

  logic                    clk = 1'b0;
  logic                    rst;
  logic                    i_cfg_wr_stb;
  logic [`SDIO_ADDR_W-1:0] i_cfg_addr;
  logic [`SDIO_LEN_W-1:0]  i_cfg_wdata;
  logic                    i_rd_stb;
  logic [7:0]              i_rd_data;
  logic [3:0]              i_sd_dat;
  wire                     o_busy;
  wire                     o_crc_good;
  wire                     o_done;
  wire                     o_wr_stb;
  wire  [7:0]              o_wr_data;
  wire                     o_rd_req;
  wire  [3:0]              o_sd_dat;
  wire                     o_sd_dir;
  wire  [31:0]             err_count;

  row_t        rows [NROWS];
  row_t        cur;
  logic [15:0] host_crc [4];
  logic        rd_pending = 1'b0;
  int          rd_idx;
  int          limit;
  int          seed_draw;

  always #4 clk = ~clk;

  sdio_data_top u_dut (.*);

  sdio_data_checker u_chk (
    .clk        (clk),
    .rst        (rst),
    .i_dir      (cur.dir),
    .i_len      (cur.len),
    .i_base     (cur.base),
    .i_step     (cur.step),
    .i_corrupt  (cur.corrupt),
    .i_busy     (o_busy),
    .i_done     (o_done),
    .i_crc_good (o_crc_good),
    .i_wr_stb   (o_wr_stb),
    .i_wr_data  (o_wr_data),
    .i_rd_req   (o_rd_req),
    .i_sd_dat   (o_sd_dat),
    .i_sd_dir   (o_sd_dir),
    .o_errors   (err_count)
  );

  task automatic cfg_write(input logic [`SDIO_ADDR_W-1:0] addr, input logic [9:0] data);
    @(negedge clk);
    i_cfg_wr_stb = 1'b1;
    i_cfg_addr   = addr;
    i_cfg_wdata  = data;
    @(negedge clk);
    i_cfg_wr_stb = 1'b0;
  endtask

  task automatic send_nibble(input logic [3:0] nib);
    @(negedge clk);
    i_sd_dat = nib;
  endtask

  // Data nibbles also run through the host's own line CRCs
  task automatic emit_data_nibble(input logic [3:0] nib);
    send_nibble(nib);
    for (int g = 0; g < 4; g++) begin
      host_crc[g] = {host_crc[g][14:0], 1'b0} ^
                    ((host_crc[g][15] ^ nib[g]) ? `SDIO_CRC_POLY : 16'h0);
    end
  endtask

  // Host drives an idle gap, the start nibble, data, CRCs and the end nibble
  task automatic host_write();
    sdio_byte_u b;
    int         lane;
    for (int g = 0; g < 4; g++) begin
      host_crc[g] = '0;
    end
    repeat ($urandom_range(6, 0)) @(negedge clk);
    send_nibble(4'h0);
    for (int k = 0; k < cur.len; k++) begin
      b.data = cur.base + 8'(k) * cur.step;
      emit_data_nibble(b.nib.hi);
      emit_data_nibble(b.nib.lo);
    end
    if (cur.corrupt) begin
      lane           = $urandom_range(3, 0);
      host_crc[lane] = host_crc[lane] ^ (16'h1 << $urandom_range(15, 0));
    end
    for (int i = 15; i >= 0; i--) begin
      send_nibble({host_crc[3][i], host_crc[2][i], host_crc[1][i], host_crc[0][i]});
    end
    send_nibble(4'hF);
  endtask

  // Source answers each request in the following cycle
  always @(negedge clk) begin
    i_rd_stb = rd_pending;
    if (rd_pending) begin
      i_rd_data = cur.base + 8'(rd_idx) * cur.step;
      rd_idx++;
    end
    rd_pending = o_rd_req;
  end

  initial begin
    seed_draw    = $urandom(32'h14d2_25ad);
    rst          = 1'b1;
    i_cfg_wr_stb = 1'b0;
    i_cfg_addr   = '0;
    i_cfg_wdata  = '0;
    i_rd_stb     = 1'b0;
    i_rd_data    = '0;
    i_sd_dat     = 4'hF;
    cur          = '0;
    rows[0] = {SDIO_DIR_READ,  10'd1,   8'h3C, 8'h00, 1'b0, 1'b0};
    rows[1] = {SDIO_DIR_WRITE, 10'd1,   8'hC3, 8'h00, 1'b0, 1'b0};
    rows[2] = {SDIO_DIR_READ,  10'd16,  8'h00, 8'h11, 1'b0, 1'b0};
    rows[3] = {SDIO_DIR_WRITE, 10'd16,  8'h10, 8'h07, 1'b0, 1'b0};
    rows[4] = {SDIO_DIR_WRITE, 10'd8,   8'h5A, 8'h03, 1'b1, 1'b0};
    rows[5] = {SDIO_DIR_READ,  10'd4,   8'hF0, 8'h01, 1'b0, 1'b1};
    rows[6] = {SDIO_DIR_WRITE, 10'd6,   8'h21, 8'h0D, 1'b1, 1'b1};
    rows[7] = {SDIO_DIR_READ,  10'd512, 8'h01, 8'h01, 1'b0, 1'b0};
    rows[8] = {SDIO_DIR_WRITE, 10'd512, 8'h80, 8'h05, 1'b0, 1'b0};
    limit = 200;
    for (int r = 0; r < NROWS; r++) begin
      limit += 2 * rows[r].len + 40;
    end
    fork
      begin
        repeat (limit) @(posedge clk);
        $display("Timeout: transfers did not finish within %0d cycles", limit);
        $display("Test failures found");
        $finish;
      end
    join_none
    repeat (8) @(negedge clk);
    rst = 1'b0;
    for (int r = 0; r < NROWS; r++) begin
      cur    = rows[r];
      rd_idx = 0;
      cfg_write(`SDIO_REG_LEN, cur.len);
      cfg_write(`SDIO_REG_CTRL, {8'h00, 1'b1, cur.dir});
      // Second go with the other direction lands while busy and must be dropped
      if (cur.extra_go) begin
        cfg_write(`SDIO_REG_CTRL, {8'h00, 1'b1, ~cur.dir});
      end
      if (cur.dir == SDIO_DIR_WRITE) begin
        host_write();
      end
      while (!o_done) @(negedge clk);
      repeat (4) @(negedge clk);
    end
    $display("Run complete: %0d errors", err_count);
    if (err_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+src
src/sdio_data_pkg.sv
src/sdio_data_if.sv
src/sdio_crc16_lane.sv
src/sdio_data_cfg.sv
src/sdio_data_phy.sv
src/sdio_data_top.sv
tests/sdio_data_checker.sv
tests/tb_sdio_data.sv
